// File: source/tinker_cfg.svh
/*
 * Tinker core configuration
 * Widths, register count, memory size and program-counter constants
 * shared by the RTL of the core.
 */
`ifndef TINKER_CFG_SVH
`define TINKER_CFG_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define TINKER_XLEN 64
`define TINKER_ILEN 32

// architectural registers
`define TINKER_NREGS 32

// ------------------------------
// memory and program counter
// ------------------------------
// byte count, power of two
`define TINKER_MEM_BYTES 4096
`define TINKER_PC_STEP 4
`define TINKER_START_PC 0

`endif

// File: source/tinker_pkg.sv
/*
 * Tinker shared types
 * Opcode and stage encodings plus the decoded-instruction record
 * passed from the decoder to the core.
 */
package tinker_pkg;

    // reference opcode encodings, bits 31:27
    typedef enum logic [4:0] {
        op_and    = 5'b00000,
        op_or     = 5'b00001,
        op_xor    = 5'b00010,
        op_not    = 5'b00011,
        op_shftr  = 5'b00100,
        op_shftri = 5'b00101,
        op_shftl  = 5'b00110,
        op_shftli = 5'b00111,
        op_jump   = 5'b01000,
        op_jrel   = 5'b01001,
        op_brr    = 5'b01010,
        op_brnz   = 5'b01011,
        op_brgt   = 5'b01110,
        op_halt   = 5'b01111,
        op_load   = 5'b10000,
        op_mov    = 5'b10001,
        op_mov_l  = 5'b10010,
        op_store  = 5'b10011,
        op_add    = 5'b11000,
        op_addi   = 5'b11001,
        op_sub    = 5'b11010,
        op_subi   = 5'b11011,
        op_mul    = 5'b11100
    } opcode_e;

    // one instruction per pass through these
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } stage_e;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [11:0] l;
        logic        uses_imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        is_branch;
        logic        is_halt;
        logic        illegal;
    } decoded_t;

endpackage

// File: source/tinker_mem_if.sv
/*
 * Tinker memory bus
 * Instruction fetch and data access between core and byte memory.
 * Reads are combinational, writes land on the clock edge.
 */
`timescale 1ns/1ps
`include "tinker_cfg.svh"

interface tinker_mem_if;

    // ------------------------------
    // core side
    // ------------------------------
    logic [`TINKER_XLEN-1:0] fetch_addr;
    logic [`TINKER_XLEN-1:0] data_addr;
    logic [`TINKER_XLEN-1:0] write_data;
    // stores 8 bytes at data_addr
    logic                    write_en;

    // ------------------------------
    // memory side
    // ------------------------------
    logic [`TINKER_ILEN-1:0] instruction;
    logic [`TINKER_XLEN-1:0] read_data;

    modport core (
        output fetch_addr, data_addr, write_data, write_en,
        input  instruction, read_data
    );

    modport mem (
        input  fetch_addr, data_addr, write_data, write_en,
        output instruction, read_data
    );

endinterface

// File: source/tinker_decoder.sv
/*
 * Tinker instruction decoder
 * Splits an instruction word into its fields and derives the
 * control flags used by the core.
 */
`timescale 1ns/1ps
`include "tinker_cfg.svh"

module tinker_decoder (
    input  logic [`TINKER_ILEN-1:0] instruction,
    output tinker_pkg::decoded_t    dec
);

    always_comb begin
        // raw fields
        dec.op        = tinker_pkg::opcode_e'(instruction[31:27]);
        dec.rd        = instruction[26:22];
        dec.rs        = instruction[21:17];
        dec.rt        = instruction[16:12];
        dec.l         = instruction[11:0];
        dec.uses_imm  = 1'b0;
        dec.reg_write = 1'b0;
        dec.mem_read  = 1'b0;
        dec.mem_write = 1'b0;
        dec.is_branch = 1'b0;
        dec.is_halt   = 1'b0;
        dec.illegal   = 1'b0;
        case (dec.op)
            // register-register ops
            tinker_pkg::op_add, tinker_pkg::op_sub, tinker_pkg::op_mul,
            tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor,
            tinker_pkg::op_not, tinker_pkg::op_shftr, tinker_pkg::op_shftl,
            tinker_pkg::op_mov:
                dec.reg_write = 1'b1;
            // L replaces rt
            tinker_pkg::op_addi, tinker_pkg::op_subi, tinker_pkg::op_shftri,
            tinker_pkg::op_shftli, tinker_pkg::op_mov_l: begin
                dec.uses_imm  = 1'b1;
                dec.reg_write = 1'b1;
            end
            tinker_pkg::op_load: begin
                dec.uses_imm  = 1'b1;
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            tinker_pkg::op_store: begin
                dec.uses_imm  = 1'b1;
                dec.mem_write = 1'b1;
            end
            // brr is pc-relative on L
            tinker_pkg::op_brr: begin
                dec.uses_imm  = 1'b1;
                dec.is_branch = 1'b1;
            end
            tinker_pkg::op_jump, tinker_pkg::op_jrel, tinker_pkg::op_brnz,
            tinker_pkg::op_brgt:
                dec.is_branch = 1'b1;
            tinker_pkg::op_halt:
                dec.is_halt = 1'b1;
            default:
                dec.illegal = 1'b1;
        endcase
    end

    // programs loaded into memory only hold kept opcodes
    always_comb begin
        if (!$isunknown(instruction)) begin
            assert #0 (!dec.illegal)
                else $error("illegal opcode %b", instruction[31:27]);
        end
    end

endmodule

// File: source/tinker_regfile.sv
/*
 * Tinker register file
 * 32 x 64-bit registers, three operand read ports, one debug read
 * port and one write port.
 */
`timescale 1ns/1ps
`include "tinker_cfg.svh"

module tinker_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    write_en,
    input  logic [4:0]              write_addr,
    input  logic [`TINKER_XLEN-1:0] write_data,
    input  logic [4:0]              rs_addr,
    input  logic [4:0]              rt_addr,
    input  logic [4:0]              rd_addr,
    input  logic [4:0]              dbg_addr,
    output logic [`TINKER_XLEN-1:0] rs_val,
    output logic [`TINKER_XLEN-1:0] rt_val,
    output logic [`TINKER_XLEN-1:0] rd_val,
    output logic [`TINKER_XLEN-1:0] dbg_val
);

    logic [`TINKER_XLEN-1:0] regs [`TINKER_NREGS];

    // ------------------------------
    // write port
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // all registers start at zero, r31 included
            for (int i = 0; i < `TINKER_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // ------------------------------
    // read ports, no bypass
    // ------------------------------
    assign rs_val  = regs[rs_addr];
    assign rt_val  = regs[rt_addr];
    assign rd_val  = regs[rd_addr];
    // debug view for the test side
    assign dbg_val = regs[dbg_addr];

endmodule

// File: source/tinker_alu.sv
/*
 * Tinker ALU
 * Integer result, load/store effective address and next program
 * counter for one instruction.
 */
`timescale 1ns/1ps
`include "tinker_cfg.svh"

module tinker_alu (
    input  tinker_pkg::opcode_e     op,
    input  logic [`TINKER_XLEN-1:0] pc,
    input  logic [`TINKER_XLEN-1:0] a,
    input  logic [`TINKER_XLEN-1:0] b,
    input  logic [`TINKER_XLEN-1:0] rd_val,
    output logic [`TINKER_XLEN-1:0] result,
    output logic [`TINKER_XLEN-1:0] mem_addr,
    output logic [`TINKER_XLEN-1:0] next_pc
);

    logic [`TINKER_XLEN-1:0] pc_plus;

    assign pc_plus = pc + `TINKER_XLEN'(`TINKER_PC_STEP);

    // ------------------------------
    // integer result
    // ------------------------------
    always_comb begin
        case (op)
            tinker_pkg::op_add, tinker_pkg::op_addi:
                result = a + b;
            tinker_pkg::op_sub, tinker_pkg::op_subi:
                result = a - b;
            // low 64 bits of the product
            tinker_pkg::op_mul:
                result = a * b;
            tinker_pkg::op_and:
                result = a & b;
            tinker_pkg::op_or:
                result = a | b;
            tinker_pkg::op_xor:
                result = a ^ b;
            tinker_pkg::op_not:
                result = ~a;
            // logical shifts, full b as amount
            tinker_pkg::op_shftr, tinker_pkg::op_shftri:
                result = a >> b;
            tinker_pkg::op_shftl, tinker_pkg::op_shftli:
                result = a << b;
            tinker_pkg::op_mov:
                result = a;
            // keep upper 52 bits of rd
            tinker_pkg::op_mov_l:
                result = {rd_val[`TINKER_XLEN-1:12], b[11:0]};
            default:
                result = '0;
        endcase
    end

    // store is based on rd, load on rs
    assign mem_addr = (op == tinker_pkg::op_store) ? rd_val + b : a + b;

    // ------------------------------
    // next pc
    // ------------------------------
    always_comb begin
        case (op)
            tinker_pkg::op_jump:
                next_pc = rd_val;
            tinker_pkg::op_jrel:
                next_pc = pc + rd_val;
            tinker_pkg::op_brr:
                next_pc = pc + b;
            tinker_pkg::op_brnz:
                next_pc = (a != '0) ? rd_val : pc_plus;
            // signed compare of rs and rt
            tinker_pkg::op_brgt:
                next_pc = ($signed(a) > $signed(b)) ? rd_val : pc_plus;
            default:
                next_pc = pc_plus;
        endcase
    end

endmodule

// File: source/tinker_memory.sv
/*
 * Tinker byte memory
 * Little-endian byte array with a 32-bit fetch port, a 64-bit data
 * port and a 32-bit program-load port. Contents survive reset.
 */
`timescale 1ns/1ps
`include "tinker_cfg.svh"

module tinker_memory (
    input  logic        clk,
    tinker_mem_if.mem   bus,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data
);

    localparam int AW = $clog2(`TINKER_MEM_BYTES);

    logic [7:0]    bytes [`TINKER_MEM_BYTES];
    logic [AW-1:0] fetch_idx;
    logic [AW-1:0] data_idx;
    logic [AW-1:0] load_idx;

    // addresses wrap inside the array
    assign fetch_idx = bus.fetch_addr[AW-1:0];
    assign data_idx  = bus.data_addr[AW-1:0];
    assign load_idx  = load_addr[AW-1:0];

    // ------------------------------
    // combinational reads
    // ------------------------------
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            bus.instruction[8*k +: 8] = bytes[fetch_idx + AW'(k)];
        end
        for (int k = 0; k < 8; k++) begin
            bus.read_data[8*k +: 8] = bytes[data_idx + AW'(k)];
        end
    end

    // ------------------------------
    // writes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (bus.write_en) begin
            for (int k = 0; k < 8; k++) begin
                bytes[data_idx + AW'(k)] <= bus.write_data[8*k +: 8];
            end
        end else if (load_en) begin
            // one instruction word per edge
            for (int k = 0; k < 4; k++) begin
                bytes[load_idx + AW'(k)] <= load_data[8*k +: 8];
            end
        end
    end

    // store from the core never wraps past the top
    assert property (@(posedge clk)
        bus.write_en |-> bus.data_addr <= `TINKER_MEM_BYTES - 8);

    // program load only happens while the core sits idle
    assert property (@(posedge clk) !(load_en && bus.write_en));

endmodule

// File: source/tinker_core.sv
/*
 * Tinker core top level
 * Runs one instruction at a time through fetch, decode, execute,
 * memory and writeback. Holds the pc, the stage registers and the
 * halt flag, plus program-load and debug register ports.
 */
`timescale 1ns/1ps
`include "tinker_cfg.svh"

module tinker_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    load_en,
    input  logic [31:0]             load_addr,
    input  logic [31:0]             load_data,
    input  logic [4:0]              dbg_addr,
    output logic [`TINKER_XLEN-1:0] dbg_data,
    output logic                    hlt
);

    // ------------------------------
    // state and stage registers
    // ------------------------------
    tinker_pkg::stage_e      stage;
    logic [`TINKER_XLEN-1:0] pc;
    logic                    hlt_q;
    logic [`TINKER_ILEN-1:0] ir;
    // operands latched in decode
    logic [`TINKER_XLEN-1:0] a_q;
    logic [`TINKER_XLEN-1:0] b_q;
    logic [`TINKER_XLEN-1:0] rdv_q;
    // execute results
    logic [`TINKER_XLEN-1:0] result_q;
    logic [`TINKER_XLEN-1:0] maddr_q;
    logic [`TINKER_XLEN-1:0] npc_q;
    logic [`TINKER_XLEN-1:0] load_q;

    tinker_pkg::decoded_t    dec;
    logic [`TINKER_XLEN-1:0] rs_val;
    logic [`TINKER_XLEN-1:0] rt_val;
    logic [`TINKER_XLEN-1:0] rd_val;
    logic [`TINKER_XLEN-1:0] l_ext;
    logic [`TINKER_XLEN-1:0] alu_result;
    logic [`TINKER_XLEN-1:0] alu_addr;
    logic [`TINKER_XLEN-1:0] alu_npc;
    logic [`TINKER_XLEN-1:0] wb_data;
    logic                    rf_write;

    tinker_mem_if mem_bus ();

    // ------------------------------
    // submodules
    // ------------------------------
    tinker_memory mem0 (
        .clk       (clk),
        .bus       (mem_bus.mem),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // ir is stable from decode through writeback
    tinker_decoder dec0 (
        .instruction (ir),
        .dec         (dec)
    );

    tinker_regfile rf0 (
        .clk        (clk),
        .reset      (reset),
        .write_en   (rf_write),
        .write_addr (dec.rd),
        .write_data (wb_data),
        .rs_addr    (dec.rs),
        .rt_addr    (dec.rt),
        .rd_addr    (dec.rd),
        .dbg_addr   (dbg_addr),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .rd_val     (rd_val),
        .dbg_val    (dbg_data)
    );

    tinker_alu alu0 (
        .op       (dec.op),
        .pc       (pc),
        .a        (a_q),
        .b        (b_q),
        .rd_val   (rdv_q),
        .result   (alu_result),
        .mem_addr (alu_addr),
        .next_pc  (alu_npc)
    );

    // ------------------------------
    // memory bus
    // ------------------------------
    assign mem_bus.fetch_addr = pc;
    assign mem_bus.data_addr  = maddr_q;
    // store writes rs
    assign mem_bus.write_data = a_q;
    assign mem_bus.write_en   = (stage == tinker_pkg::st_memory) && dec.mem_write;

    assign l_ext    = {{(`TINKER_XLEN-12){dec.l[11]}}, dec.l};
    assign wb_data  = dec.mem_read ? load_q : result_q;
    assign rf_write = (stage == tinker_pkg::st_writeback) && dec.reg_write;
    assign hlt      = hlt_q;

    // ------------------------------
    // stage sequencer
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage <= tinker_pkg::st_idle;
            pc    <= `TINKER_XLEN'(`TINKER_START_PC);
            hlt_q <= 1'b0;
        end else begin
            case (stage)
                tinker_pkg::st_idle:
                    if (start) stage <= tinker_pkg::st_fetch;
                tinker_pkg::st_fetch:
                    stage <= tinker_pkg::st_decode;
                tinker_pkg::st_decode:
                    stage <= tinker_pkg::st_execute;
                tinker_pkg::st_execute:
                    stage <= tinker_pkg::st_memory;
                tinker_pkg::st_memory:
                    stage <= tinker_pkg::st_writeback;
                tinker_pkg::st_writeback: begin
                    pc <= dec.is_branch ? npc_q : pc + `TINKER_XLEN'(`TINKER_PC_STEP);
                    // unknown opcode stops the core as halt does
                    if (dec.is_halt || dec.illegal) begin
                        stage <= tinker_pkg::st_halted;
                        hlt_q <= 1'b1;
                    end else begin
                        stage <= tinker_pkg::st_fetch;
                    end
                end
                // halted only leaves on reset
                default:
                    stage <= tinker_pkg::st_halted;
            endcase
        end
    end

    // ------------------------------
    // stage payload registers
    // ------------------------------
    always_ff @(posedge clk) begin
        case (stage)
            tinker_pkg::st_fetch:
                ir <= mem_bus.instruction;
            tinker_pkg::st_decode: begin
                a_q   <= rs_val;
                b_q   <= dec.uses_imm ? l_ext : rt_val;
                rdv_q <= rd_val;
            end
            tinker_pkg::st_execute: begin
                result_q <= alu_result;
                maddr_q  <= alu_addr;
                npc_q    <= alu_npc;
            end
            tinker_pkg::st_memory:
                if (dec.mem_read) load_q <= mem_bus.read_data;
            default: ;
        endcase
    end

    // halt level holds until the next reset
    assert property (@(posedge clk) disable iff (reset) hlt |=> hlt);

    // program loading never overlaps execution
    assert property (@(posedge clk) disable iff (reset)
        load_en |-> stage == tinker_pkg::st_idle);

endmodule

// File: verification/tinker_tb_programs.svh
/*
 * Tinker testbench programs
 * Instruction encoding, reference model, program builder and the
 * table of test rows with their expected results.
 */
`ifndef TINKER_TB_PROGRAMS_SVH
`define TINKER_TB_PROGRAMS_SVH

typedef enum {k_alu, k_mem, k_branch, k_halt, k_reset} kind_e;

typedef struct {
    kind_e               kind;
    tinker_pkg::opcode_e op;
    logic [63:0]         a;
    logic [63:0]         b;
    logic [63:0]         expected;
    int                  n_exec;
} row_t;

localparam int NUM_ROWS = 25;
// longest program, the alu rows
localparam int MAX_PROG = 25;

row_t        rows [NUM_ROWS];
int          row_count;
logic [31:0] prog [$];

// ------------------------------
// encoding helpers
// ------------------------------
function automatic logic [31:0] encode(tinker_pkg::opcode_e op, logic [4:0] rd,
                                       logic [4:0] rs, logic [4:0] rt, logic [11:0] l);
    return {op, rd, rs, rt, l};
endfunction

function automatic logic [63:0] sext12(logic [11:0] v);
    return {{52{v[11]}}, v};
endfunction

function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
endfunction

function automatic logic [11:0] rand12();
    return 12'($urandom());
endfunction

// ------------------------------
// reference model
// ------------------------------
// b is already the sign-extended L for immediate forms
function automatic logic [63:0] model_alu(tinker_pkg::opcode_e op, logic [63:0] a,
                                          logic [63:0] b);
    case (op)
        tinker_pkg::op_add, tinker_pkg::op_addi:     return a + b;
        tinker_pkg::op_sub, tinker_pkg::op_subi:     return a - b;
        tinker_pkg::op_mul:                          return a * b;
        tinker_pkg::op_and:                          return a & b;
        tinker_pkg::op_or:                           return a | b;
        tinker_pkg::op_xor:                          return a ^ b;
        tinker_pkg::op_not:                          return ~a;
        tinker_pkg::op_shftr, tinker_pkg::op_shftri: return a >> b;
        tinker_pkg::op_shftl, tinker_pkg::op_shftli: return a << b;
        tinker_pkg::op_mov:                          return a;
        // rd holds a copy of a before the op
        tinker_pkg::op_mov_l:                        return {a[63:12], b[11:0]};
        default:                                     return '0;
    endcase
endfunction

function automatic bit model_taken(tinker_pkg::opcode_e op, logic [63:0] a, logic [63:0] b);
    case (op)
        tinker_pkg::op_brnz: return a != '0;
        tinker_pkg::op_brgt: return $signed(a) > $signed(b);
        // jump, jump rel and brr always redirect
        default:             return 1'b1;
    endcase
endfunction

task automatic add_row(kind_e kind, tinker_pkg::opcode_e op, logic [63:0] a, logic [63:0] b);
    row_t r;
    r.kind     = kind;
    r.op       = op;
    r.a        = a;
    r.b        = b;
    r.expected = '0;
    r.n_exec   = 0;
    case (kind)
        k_alu: begin
            r.expected = model_alu(op, a, b);
            r.n_exec   = 25;
        end
        k_mem: begin
            r.expected = a;
            r.n_exec   = 15;
        end
        // marker in r5 only survives a fall-through
        k_branch: begin
            r.expected = model_taken(op, a, b) ? 64'd0 : 64'd1;
            r.n_exec   = model_taken(op, a, b) ? 5 : 6;
        end
        k_halt:
            r.n_exec = 2;
        default: ;
    endcase
    rows[row_count] = r;
    row_count++;
endtask

// ------------------------------
// program builder
// ------------------------------
// 4 + 5 x 12 bits, top nibble first
task automatic push_const(logic [4:0] rd, logic [63:0] v);
    prog.push_back(encode(tinker_pkg::op_addi, rd, 5'd0, 5'd0, {8'h00, v[63:60]}));
    for (int k = 4; k >= 0; k--) begin
        prog.push_back(encode(tinker_pkg::op_shftli, rd, rd, 5'd0, 12'd12));
        prog.push_back(encode(tinker_pkg::op_mov_l, rd, 5'd0, 5'd0, v[12*k +: 12]));
    end
endtask

task automatic build_program(row_t r);
    prog.delete();
    case (r.kind)
        k_alu, k_reset: begin
            push_const(5'd1, r.a);
            push_const(5'd2, r.b);
            prog.push_back(encode(tinker_pkg::op_mov, 5'd3, 5'd1, 5'd0, 12'd0));
            prog.push_back(encode(r.op, 5'd3, 5'd1, 5'd2, r.b[11:0]));
        end
        // store r1 at 0x400 and load it back into r4
        k_mem: begin
            push_const(5'd1, r.a);
            prog.push_back(encode(tinker_pkg::op_addi, 5'd2, 5'd0, 5'd0, 12'h400));
            prog.push_back(encode(tinker_pkg::op_store, 5'd2, 5'd1, 5'd0, 12'd0));
            prog.push_back(encode(tinker_pkg::op_load, 5'd4, 5'd2, 5'd0, 12'd0));
        end
        // branch at 12, marker at 16, halt at 20
        k_branch: begin
            prog.push_back(encode(tinker_pkg::op_addi, 5'd1, 5'd0, 5'd0, r.a[11:0]));
            prog.push_back(encode(tinker_pkg::op_addi, 5'd2, 5'd0, 5'd0, r.b[11:0]));
            prog.push_back(encode(tinker_pkg::op_addi, 5'd3, 5'd0, 5'd0,
                                  (r.op == tinker_pkg::op_jrel) ? 12'd8 : 12'd20));
            prog.push_back(encode(r.op, 5'd3, 5'd1, 5'd2, 12'd8));
            prog.push_back(encode(tinker_pkg::op_addi, 5'd5, 5'd0, 5'd0, 12'd1));
        end
        default:
            prog.push_back(encode(tinker_pkg::op_addi, 5'd1, 5'd0, 5'd0, 12'd7));
    endcase
    prog.push_back(encode(tinker_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'd0));
    // never reached
    if (r.kind == k_halt) begin
        prog.push_back(encode(tinker_pkg::op_addi, 5'd6, 5'd0, 5'd0, 12'd1));
    end
endtask

// ------------------------------
// test table
// ------------------------------
task automatic build_table();
    row_count = 0;
    add_row(k_alu, tinker_pkg::op_add, rand64(), rand64());
    add_row(k_alu, tinker_pkg::op_addi, rand64(), sext12(rand12()));
    add_row(k_alu, tinker_pkg::op_sub, rand64(), rand64());
    add_row(k_alu, tinker_pkg::op_subi, rand64(), sext12(rand12()));
    add_row(k_alu, tinker_pkg::op_mul, rand64(), rand64());
    add_row(k_alu, tinker_pkg::op_and, rand64(), rand64());
    add_row(k_alu, tinker_pkg::op_or, rand64(), rand64());
    add_row(k_alu, tinker_pkg::op_xor, rand64(), rand64());
    add_row(k_alu, tinker_pkg::op_not, rand64(), rand64());
    // shift amounts kept below 64
    add_row(k_alu, tinker_pkg::op_shftr, rand64(), 64'($urandom_range(63)));
    add_row(k_alu, tinker_pkg::op_shftri, rand64(), 64'($urandom_range(63)));
    add_row(k_alu, tinker_pkg::op_shftl, rand64(), 64'($urandom_range(63)));
    add_row(k_alu, tinker_pkg::op_shftli, rand64(), 64'($urandom_range(63)));
    add_row(k_alu, tinker_pkg::op_mov, rand64(), rand64());
    add_row(k_alu, tinker_pkg::op_mov_l, rand64(), sext12(rand12()));
    add_row(k_mem, tinker_pkg::op_store, rand64(), '0);
    add_row(k_branch, tinker_pkg::op_jump, '0, '0);
    add_row(k_branch, tinker_pkg::op_jrel, '0, '0);
    add_row(k_branch, tinker_pkg::op_brr, '0, '0);
    add_row(k_branch, tinker_pkg::op_brnz, sext12(rand12() | 12'h001), '0);
    add_row(k_branch, tinker_pkg::op_brnz, '0, '0);
    // signed compare, unsigned would invert both
    add_row(k_branch, tinker_pkg::op_brgt, sext12(12'd3), sext12(12'hffb));
    add_row(k_branch, tinker_pkg::op_brgt, sext12(12'hffb), sext12(12'd3));
    add_row(k_halt, tinker_pkg::op_halt, '0, '0);
    add_row(k_reset, tinker_pkg::op_add, rand64() | 64'h8000_0000_0000_0000, rand64());
endtask

`endif

// File: verification/tinker_tb.sv
/*
 * Tinker core testbench
 * Loads short programs through the load port, runs each to halt and
 * checks registers, halt timing and reset against a reference model.
 */
`timescale 1ns/1ps

module tinker_tb;

    localparam int PERIOD = 4;
    // reset, register scan and program load per row
    localparam int LOAD_CYCLES = 80;

    logic        clk;
    logic        reset;
    logic        start;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic [4:0]  dbg_addr;
    logic [63:0] dbg_data;
    logic        hlt;

    `include "tinker_tb_programs.svh"

    localparam int WATCHDOG_CYCLES = NUM_ROWS * (LOAD_CYCLES + 5 * MAX_PROG + 20);

    tinker_core dut0 (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .hlt       (hlt)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ------------------------------
    // reporting and checks
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
            else report_failure($sformatf("Mismatch at %0t: %s expected %h got %h",
                                          $time, name, exp, got));
    endtask

    // debug port is combinational so sample 1 ns after the drive
    task automatic read_reg(input int idx, output logic [63:0] val);
        @(negedge clk);
        dbg_addr = idx[4:0];
        #1;
        val = dbg_data;
    endtask

    // ------------------------------
    // DUT sequencing
    // ------------------------------
    task automatic apply_reset();
        logic [63:0] val;
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_value("hlt after reset", 64'(hlt), 64'd0);
        for (int i = 0; i < 32; i++) begin
            read_reg(i, val);
            check_value($sformatf("r%0d after reset", i), val, '0);
        end
    endtask

    // one word per edge while the core is idle
    task automatic load_program();
        foreach (prog[i]) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = 32'(4 * i);
            load_data = prog[i];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        logic [63:0] val;
        int          cycles;
        apply_reset();
        build_program(r);
        load_program();
        // the edge inside the start pulse counts as cycle 0
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (r.kind == k_reset) begin
            // stop after a few writebacks while the program still runs
            repeat (40) @(negedge clk);
            read_reg(1, val);
            assert (val !== '0)
                else report_failure("r1 was never written before the mid-program reset");
            apply_reset();
        end else begin
            cycles = 0;
            while (hlt !== 1'b1) begin
                @(negedge clk);
                cycles++;
            end
            check_value("hlt rise cycle", 64'(cycles), 64'(5 * r.n_exec));
            // halt level must hold
            repeat (20) begin
                @(negedge clk);
                check_value("hlt", 64'(hlt), 64'd1);
            end
            case (r.kind)
                k_alu: begin
                    read_reg(3, val);
                    check_value($sformatf("r3 (%s)", r.op.name()), val, r.expected);
                end
                k_mem: begin
                    read_reg(4, val);
                    check_value("r4 loaded", val, r.expected);
                    read_reg(1, val);
                    check_value("r1 stored", val, r.a);
                end
                k_branch: begin
                    read_reg(5, val);
                    check_value($sformatf("r5 (%s)", r.op.name()), val, r.expected);
                end
                default: begin
                    read_reg(6, val);
                    check_value("r6 after halt", val, r.expected);
                end
            endcase
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        // seed the generator for the operand draws
        void'($urandom(47));
        build_table();
        for (int i = 0; i < row_count; i++) begin
            run_row(rows[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // bound from row count and longest program
    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        report_failure("timeout: the test rows did not complete in the allowed time");
    end

endmodule

// File: filelist.f
+incdir+source
+incdir+verification
source/tinker_pkg.sv
source/tinker_mem_if.sv
source/tinker_decoder.sv
source/tinker_regfile.sv
source/tinker_alu.sv
source/tinker_memory.sv
source/tinker_core.sv
verification/tinker_tb.sv

// File: Bender.yml
package:
  name: tinker_core

sources:
  - include_dirs:
      - source
    files:
      - source/tinker_pkg.sv
      - source/tinker_mem_if.sv
      - source/tinker_decoder.sv
      - source/tinker_regfile.sv
      - source/tinker_alu.sv
      - source/tinker_memory.sv
      - source/tinker_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tinker_tb.sv
